// File: logic/acq_params.svh
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

// Antenna sign bits in one sample
`define ACQ_AXNUM 24

// Sample buffer geometry
`define ACQ_ABITS 6
`define ACQ_DEPTH 64

// Words in each stream frame
`define ACQ_FRAME_LEN 16

// Wishbone register map
`define ACQ_REG_COUNT  2'd0
`define ACQ_REG_SYSTEM 2'd3

`endif

// File: logic/acq_pkg.sv
`include "acq_params.svh"

package acq_pkg;

   // One sign bit per antenna
   typedef logic [`ACQ_AXNUM-1:0] sample_t;

   // Tag stored alongside each sample
   typedef logic [7:0] seq_t;

   // Buffered and streamed word, tag in the top byte
   typedef logic [31:0] word_t;

   // Index into the sample buffer
   typedef logic [`ACQ_ABITS-1:0] addr_t;

   // Stream reader states, also reported in the system register
   typedef enum logic [2:0]
   {
      IDLE,
      FETCH,
      WAIT,
      SEND
   } stream_state_t;

endpackage

// File: logic/acq_sample_ram.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_sample_ram
   import acq_pkg::*;
(
   input  logic  clock_i,
   input  logic  en_i,
   input  logic  we_i,
   input  addr_t addr_i,
   input  word_t wdata_i,
   output word_t rdata_o
);

   word_t mem [`ACQ_DEPTH];

   // Registered read
   always_ff @(posedge clock_i)
   begin
      if (en_i)
      begin
         if (we_i)
            mem[addr_i] <= wdata_i;
         else
            rdata_o <= mem[addr_i];
      end
   end

endmodule

// File: logic/acq_buffer_arbiter.sv
`timescale 1ns/1ps

module acq_buffer_arbiter
   import acq_pkg::*;
(
   input  logic  clock_i,
   input  logic  M_AXIS_ARESETN,
   input  logic  wr_req_i,
   input  addr_t wr_addr_i,
   input  word_t wr_data_i,
   input  logic  rd_req_i,
   input  addr_t rd_addr_i,
   output logic  rd_gnt_o,
   output logic  rd_valid_o,
   output word_t rd_data_o,
   output logic  ram_en_o,
   output logic  ram_we_o,
   output addr_t ram_addr_o,
   output word_t ram_wdata_o,
   input  word_t ram_rdata_i
);

   // Capture has priority, the stream takes idle cycles
   assign rd_gnt_o = rd_req_i && !wr_req_i;

   // Single RAM port
   assign ram_en_o    = wr_req_i || rd_req_i;
   assign ram_we_o    = wr_req_i;
   assign ram_addr_o  = wr_req_i ? wr_addr_i : rd_addr_i;
   assign ram_wdata_o = wr_data_i;

   // RAM output is registered, so data lands one cycle after grant
   assign rd_data_o = ram_rdata_i;

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_gnt_o;
   end

   // Granted read owns the port and returns next cycle
   assert property (@(posedge clock_i) disable iff (!M_AXIS_ARESETN)
      rd_gnt_o |-> !ram_we_o ##1 rd_valid_o);

endmodule

// File: logic/acq_capture.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_capture
   import acq_pkg::*;
(
   input  logic                clock_i,
   input  logic                M_AXIS_ARESETN,
   input  logic                enable_i,
   input  logic                locked_i,
   input  logic                strobe_i,
   input  sample_t             signal_i,
   input  logic [`ACQ_ABITS:0] rd_ptr_i,
   input  logic                oflow_clear_i,
   output logic                wr_req_o,
   output addr_t               wr_addr_o,
   output word_t               wr_data_o,
   output logic [`ACQ_ABITS:0] wr_ptr_o,
   output logic                oflow_o
);

   logic [`ACQ_ABITS:0] wr_ptr;
   logic [`ACQ_ABITS:0] fill;
   seq_t                seq;
   logic                take;
   logic                full;
   logic                oflow;

   // --------------------------------------------------
   // Buffer occupancy
   // --------------------------------------------------

   // Unread words between the two pointers
   assign fill = wr_ptr - rd_ptr_i;

   // Full when the indices meet on different laps
   assign full = (wr_ptr[`ACQ_ABITS] != rd_ptr_i[`ACQ_ABITS]) &&
                 (wr_ptr[`ACQ_ABITS-1:0] == rd_ptr_i[`ACQ_ABITS-1:0]);

   // A strobe only counts while the front end is locked and capture enabled
   assign take = strobe_i && enable_i && locked_i;

   // Write goes to the arbiter and is taken in this same cycle
   assign wr_req_o  = take && !full;
   assign wr_addr_o = wr_ptr[`ACQ_ABITS-1:0];
   assign wr_data_o = {seq, signal_i};
   assign wr_ptr_o  = wr_ptr;
   assign oflow_o   = oflow;

   // --------------------------------------------------
   // Pointer and sequence tag
   // --------------------------------------------------

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         wr_ptr <= '0;
         seq    <= '0;
      end
      else if (wr_req_o)
      begin
         // Tag only advances for stored samples
         wr_ptr <= wr_ptr + 1'b1;
         seq    <= seq + 1'b1;
      end
   end

   // Sticky overflow flag
   // A drop in the same cycle wins over a clear
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
         oflow <= 1'b0;
      else if (take && full)
         oflow <= 1'b1;
      else if (oflow_clear_i)
         oflow <= 1'b0;
   end

   // Reader never runs ahead of the writer, so occupancy stays within the buffer
   assert property (@(posedge clock_i) disable iff (!M_AXIS_ARESETN)
      wr_req_o |=> (fill <= 7'(`ACQ_DEPTH)));

endmodule

// File: logic/acq_stream.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_stream
   import acq_pkg::*;
(
   input  logic                clock_i,
   input  logic                M_AXIS_ARESETN,
   input  logic [`ACQ_ABITS:0] wr_ptr_i,
   input  logic                rd_gnt_i,
   input  logic                rd_valid_i,
   input  word_t               rd_data_i,
   input  logic                tready_i,
   output logic                rd_req_o,
   output addr_t               rd_addr_o,
   output logic [`ACQ_ABITS:0] rd_ptr_o,
   output logic                tvalid_o,
   output word_t               tdata_o,
   output logic                tlast_o,
   output stream_state_t       state_o,
   output logic                frame_done_o
);

   localparam int BEAT_W = $clog2(`ACQ_FRAME_LEN);

   stream_state_t       state;
   logic [`ACQ_ABITS:0] rd_ptr;
   logic [`ACQ_ABITS:0] fill;
   logic [BEAT_W-1:0]   beat;
   logic                last_beat;
   logic                accept;
   word_t               hold;

   // Words written but not yet fetched
   assign fill = wr_ptr_i - rd_ptr;

   assign last_beat = (beat == BEAT_W'(`ACQ_FRAME_LEN - 1));

   // One outstanding read, issued only from FETCH
   assign rd_req_o  = (state == FETCH);
   assign rd_addr_o = rd_ptr[`ACQ_ABITS-1:0];
   assign rd_ptr_o  = rd_ptr;

   // --------------------------------------------------
   // Stream port
   // --------------------------------------------------
   assign tvalid_o     = (state == SEND);
   assign tdata_o      = hold;
   assign tlast_o      = tvalid_o && last_beat;
   assign accept       = tvalid_o && tready_i;
   assign frame_done_o = accept && last_beat;
   assign state_o      = state;

   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         state  <= IDLE;
         rd_ptr <= '0;
         beat   <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               // Wait for a whole frame in the buffer
               if (fill >= 7'(`ACQ_FRAME_LEN))
                  state <= FETCH;
            FETCH:
               // Read pointer moves on at grant
               if (rd_gnt_i)
               begin
                  rd_ptr <= rd_ptr + 1'b1;
                  state  <= WAIT;
               end
            WAIT:
               if (rd_valid_i)
                  state <= SEND;
            SEND:
               if (accept)
               begin
                  beat  <= last_beat ? '0 : beat + 1'b1;
                  state <= last_beat ? IDLE : FETCH;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Output word, held until the beat is taken
   always_ff @(posedge clock_i)
   begin
      if ((state == WAIT) && rd_valid_i)
         hold <= rd_data_i;
   end

   // Stalled beat keeps both valid and data
   assert property (@(posedge clock_i) disable iff (!M_AXIS_ARESETN)
      (tvalid_o && !tready_i) |=> (tvalid_o && $stable(tdata_o)));

endmodule

// File: logic/acq_wb_regs.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_wb_regs
   import acq_pkg::*;
(
   input  logic          clock_i,
   input  logic          M_AXIS_ARESETN,
   input  logic          cyc_i,
   input  logic          stb_i,
   input  logic          we_i,
   input  logic [1:0]    adr_i,
   input  logic [7:0]    dat_i,
   output logic          ack_o,
   output logic [7:0]    dat_o,
   input  logic          oflow_i,
   input  stream_state_t state_i,
   input  logic          frame_done_i,
   output logic          enable_o,
   output logic          oflow_clear_o
);

   logic       req;
   logic       store;
   logic       enable;
   logic [7:0] frames;
   logic [7:0] system_reg;
   logic [7:0] rdata;

   // Pipelined mode, every strobed cycle is a transfer
   assign req   = cyc_i && stb_i;
   assign store = req && we_i && (adr_i == `ACQ_REG_SYSTEM);

   // Enable, overflow and stream state
   assign system_reg = {enable, 3'b000, oflow_i, state_i};

   assign oflow_clear_o = store && dat_i[3];
   assign enable_o      = enable;

   // --------------------------------------------------
   // Read decode
   // --------------------------------------------------
   always_comb
   begin
      case (adr_i)
         `ACQ_REG_COUNT:  rdata = frames;
         `ACQ_REG_SYSTEM: rdata = system_reg;
         default:         rdata = 8'h00;
      endcase
   end

   // Ack one cycle after each request
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
         ack_o <= 1'b0;
      else
         ack_o <= req;
   end

   // Read data lines up with the ack
   always_ff @(posedge clock_i)
   begin
      if (req)
         dat_o <= rdata;
   end

   // Control bit and frame counter
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         enable <= 1'b0;
         frames <= '0;
      end
      else
      begin
         if (store)
            enable <= dat_i[7];
         // Wraps at 256
         if (frame_done_i)
            frames <= frames + 1'b1;
      end
   end

   assert property (@(posedge clock_i) disable iff (!M_AXIS_ARESETN)
      ack_o |-> $past(req));

endmodule

// File: logic/acq_top.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_top
   import acq_pkg::*;
(
   input  logic       clock_i,
   input  logic       M_AXIS_ARESETN,
   input  logic       locked_i,
   input  logic       strobe_i,
   input  sample_t    signal_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  logic       we_i,
   input  logic [1:0] adr_i,
   input  logic [7:0] dat_i,
   output logic       ack_o,
   output logic [7:0] dat_o,
   output logic       tvalid_o,
   output word_t      tdata_o,
   output logic       tlast_o,
   input  logic       tready_i
);

   // Control and status
   logic                enable;
   logic                oflow_clear;
   logic                oflow;
   stream_state_t       stream_state;
   logic                frame_done;

   // Buffer pointers with wrap bits
   logic [`ACQ_ABITS:0] wr_ptr;
   logic [`ACQ_ABITS:0] rd_ptr;

   // Arbiter requests
   logic                wr_req;
   addr_t               wr_addr;
   word_t               wr_data;
   logic                rd_req;
   addr_t               rd_addr;
   logic                rd_gnt;
   logic                rd_valid;
   word_t               rd_data;

   // RAM port
   logic                ram_en;
   logic                ram_we;
   addr_t               ram_addr;
   word_t               ram_wdata;
   word_t               ram_rdata;

   acq_wb_regs u_regs (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .oflow_i        (oflow),
      .state_i        (stream_state),
      .frame_done_i   (frame_done),
      .enable_o       (enable),
      .oflow_clear_o  (oflow_clear)
   );

   acq_capture u_capture (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .enable_i       (enable),
      .locked_i       (locked_i),
      .strobe_i       (strobe_i),
      .signal_i       (signal_i),
      .rd_ptr_i       (rd_ptr),
      .oflow_clear_i  (oflow_clear),
      .wr_req_o       (wr_req),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data),
      .wr_ptr_o       (wr_ptr),
      .oflow_o        (oflow)
   );

   acq_stream u_stream (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .wr_ptr_i       (wr_ptr),
      .rd_gnt_i       (rd_gnt),
      .rd_valid_i     (rd_valid),
      .rd_data_i      (rd_data),
      .tready_i       (tready_i),
      .rd_req_o       (rd_req),
      .rd_addr_o      (rd_addr),
      .rd_ptr_o       (rd_ptr),
      .tvalid_o       (tvalid_o),
      .tdata_o        (tdata_o),
      .tlast_o        (tlast_o),
      .state_o        (stream_state),
      .frame_done_o   (frame_done)
   );

   acq_buffer_arbiter u_arbiter (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .wr_req_i       (wr_req),
      .wr_addr_i      (wr_addr),
      .wr_data_i      (wr_data),
      .rd_req_i       (rd_req),
      .rd_addr_i      (rd_addr),
      .rd_gnt_o       (rd_gnt),
      .rd_valid_o     (rd_valid),
      .rd_data_o      (rd_data),
      .ram_en_o       (ram_en),
      .ram_we_o       (ram_we),
      .ram_addr_o     (ram_addr),
      .ram_wdata_o    (ram_wdata),
      .ram_rdata_i    (ram_rdata)
   );

   acq_sample_ram u_ram (
      .clock_i        (clock_i),
      .en_i           (ram_en),
      .we_i           (ram_we),
      .addr_i         (ram_addr),
      .wdata_i        (ram_wdata),
      .rdata_o        (ram_rdata)
   );

endmodule

// File: tb/acq_tb.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_tb
   import acq_pkg::*;
();

   // Stimulus lengths in clock cycles
   localparam int IDLE_CYCLES    = 200;
   localparam int TRAFFIC_CYCLES = 4000;
   localparam int OFLOW_CYCLES   = 600;
   // Twice the stimulus length, plus room for drains and register access
   localparam int MAX_CYCLES = 2 * (IDLE_CYCLES + 2 * TRAFFIC_CYCLES + OFLOW_CYCLES) + 2400;

   logic       clock_i;
   logic       M_AXIS_ARESETN;
   logic       locked_i;
   logic       strobe_i;
   sample_t    signal_i;
   logic       cyc_i;
   logic       stb_i;
   logic       we_i;
   logic [1:0] adr_i;
   logic [7:0] dat_i;
   logic       ack_o;
   logic [7:0] dat_o;
   logic       tvalid_o;
   word_t      tdata_o;
   logic       tlast_o;
   logic       tready_i;

   // Reference model state
   word_t       model_q[$];
   seq_t        model_seq;
   logic        model_enable;
   logic        model_oflow;
   logic [7:0]  frames_seen;
   int          beat_count;
   seq_t        beat_seq;
   word_t       expected;
   logic        stalled;
   logic [31:0] lfsr;
   int          cycle_count;

   acq_top UUT (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .locked_i       (locked_i),
      .strobe_i       (strobe_i),
      .signal_i       (signal_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .tvalid_o       (tvalid_o),
      .tdata_o        (tdata_o),
      .tlast_o        (tlast_o),
      .tready_i       (tready_i)
   );

   initial
   begin
      clock_i = 1'b0;
      forever #5 clock_i = ~clock_i;
   end

   // --------------------------------------------------
   // Reporting and compares
   // --------------------------------------------------
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp)
         report_failure($sformatf("mismatch at %0t: %s expected %08h got %08h",
                                  $time, what, exp, got));
   endtask

   task automatic check_last(input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("mismatch at %0t: tlast_o expected %b got %b",
                                  $time, exp, got));
   endtask

   task automatic check_reg(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         report_failure($sformatf("mismatch at %0t: %s expected %02h got %02h",
                                  $time, what, exp, got));
   endtask

   // --------------------------------------------------
   // Random source and reference rules
   // --------------------------------------------------

   // Galois form, taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h80200003;
      return n;
   endfunction

   // One step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   // Stored word is the tag above the antenna bits
   function automatic word_t expected_word(input seq_t s, input sample_t d);
      return {s, d};
   endfunction

   // System register as the model sees it
   function automatic logic [7:0] status_word(input stream_state_t st);
      return {model_enable, 3'b000, model_oflow, st};
   endfunction

   // --------------------------------------------------
   // Model update and compare, sampled mid-cycle
   // --------------------------------------------------
   always @(negedge clock_i)
   begin
      if (M_AXIS_ARESETN)
      begin
         if (tvalid_o && (model_q.size() == 0))
            report_failure("tvalid_o went high with no captured sample");

         // Stalled beat must keep valid and the oldest unsent word
         if (stalled)
         begin
            if (!tvalid_o)
               report_failure("tvalid_o dropped while the beat was stalled");
            check_word("stalled tdata_o", tdata_o, model_q[0]);
         end

         // Strobe decision first, the held word has left the buffer
         if (strobe_i && locked_i && model_enable)
         begin
            if (model_q.size() - int'(tvalid_o) < `ACQ_DEPTH)
            begin
               model_q.push_back(expected_word(model_seq, signal_i));
               model_seq = model_seq + 8'd1;
            end
            else
               model_oflow = 1'b1;
         end

         // Beat taken at the coming edge
         if (tvalid_o && tready_i)
         begin
            expected = model_q.pop_front();
            check_word("tdata_o", tdata_o, expected);
            check_last(tlast_o, beat_count == `ACQ_FRAME_LEN - 1);
            // Every stored sample is streamed, so tags run on with the beats
            check_reg("sequence tag", tdata_o[31:24], beat_seq);
            beat_seq = beat_seq + 8'd1;
            if (beat_count == `ACQ_FRAME_LEN - 1)
            begin
               beat_count  = 0;
               frames_seen = frames_seen + 8'd1;
            end
            else
               beat_count++;
         end

         stalled = tvalid_o && !tready_i;
      end
   end

   // Run limit
   always @(posedge clock_i)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
         report_failure($sformatf("Timeout: run still busy after %0d cycles", MAX_CYCLES));
   end

   // --------------------------------------------------
   // Stimulus tasks
   // --------------------------------------------------

   // Random strobe gaps from min_gap up, tready random or held low
   task automatic run_traffic(input int cycles, input logic random_ready, input int min_gap);
      int          gap;
      logic [31:0] bits;
      gap = 0;
      for (int c = 0; c < cycles; c++)
      begin
         @(posedge clock_i);
         if (gap == 0)
         begin
            bits = take_bits(`ACQ_AXNUM);
            strobe_i <= 1'b1;
            signal_i <= bits[`ACQ_AXNUM-1:0];
            bits = take_bits(3);
            gap  = min_gap + int'(bits[2:0]);
         end
         else
         begin
            strobe_i <= 1'b0;
            gap--;
         end
         bits = take_bits(1);
         tready_i <= random_ready ? bits[0] : 1'b0;
      end
   endtask

   // One pipelined transfer, strobes paused and stream stalled
   task automatic wb_access(input logic write, input logic [1:0] adr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
      @(posedge clock_i);
      cyc_i    <= 1'b1;
      stb_i    <= 1'b1;
      we_i     <= write;
      adr_i    <= adr;
      dat_i    <= wdata;
      strobe_i <= 1'b0;
      tready_i <= 1'b0;
      @(negedge clock_i);
      if (ack_o)
         report_failure("Wishbone ack came in the request cycle");
      @(posedge clock_i);
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
      we_i  <= 1'b0;
      // Ack and read data one cycle after the request
      @(negedge clock_i);
      if (!ack_o)
         report_failure("Wishbone ack missing one cycle after the request");
      rdata = dat_o;
   endtask

   task automatic write_system(input logic [7:0] data);
      logic [7:0] unused;
      wb_access(1'b1, `ACQ_REG_SYSTEM, data, unused);
      model_enable = data[7];
      if (data[3])
         model_oflow = 1'b0;
   endtask

   task automatic read_check(input logic [1:0] adr, input logic [7:0] exp, input string what);
      logic [7:0] got;
      wb_access(1'b0, adr, 8'h00, got);
      check_reg(what, got, exp);
   endtask

   // Frame counter read back and compared with the frames seen so far
   task automatic read_frame_count(input string what);
      logic [7:0] got;
      wb_access(1'b0, `ACQ_REG_COUNT, 8'h00, got);
      check_reg(what, got, frames_seen);
   endtask

   // Stream until only a partial frame is left
   task automatic drain_stream();
      @(posedge clock_i);
      strobe_i <= 1'b0;
      tready_i <= 1'b1;
      @(negedge clock_i);
      while (!((beat_count == 0) && (model_q.size() < `ACQ_FRAME_LEN) && !tvalid_o))
         @(negedge clock_i);
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial
   begin
      lfsr           = 32'h7533;
      model_seq      = '0;
      model_enable   = 1'b0;
      model_oflow    = 1'b0;
      frames_seen    = '0;
      beat_count     = 0;
      beat_seq       = '0;
      stalled        = 1'b0;
      cycle_count    = 0;
      M_AXIS_ARESETN = 1'b0;
      locked_i       = 1'b1;
      strobe_i       = 1'b0;
      signal_i       = '0;
      cyc_i          = 1'b0;
      stb_i          = 1'b0;
      we_i           = 1'b0;
      adr_i          = '0;
      dat_i          = '0;
      tready_i       = 1'b0;
      repeat (16) @(posedge clock_i);
      M_AXIS_ARESETN <= 1'b1;

      // Capture disabled, nothing may be stored
      read_check(`ACQ_REG_SYSTEM, 8'h00, "system register after reset");
      run_traffic(IDLE_CYCLES, 1'b1, 4);
      read_check(`ACQ_REG_SYSTEM, status_word(IDLE), "system register while disabled");

      // Enabled with random back-pressure
      write_system(8'h80);
      run_traffic(TRAFFIC_CYCLES, 1'b1, 4);
      read_frame_count("frame count");
      if (frames_seen == 8'd0)
         report_failure("No frame completed during random traffic");

      // Stream stalled until the buffer overflows
      run_traffic(OFLOW_CYCLES, 1'b0, 0);
      if (!model_oflow)
         report_failure("Buffer never filled while the stream was stalled");
      read_check(`ACQ_REG_SYSTEM, status_word(SEND), "system register after overflow");

      // Clear the flag, then resume
      write_system(8'h88);
      read_check(`ACQ_REG_SYSTEM, status_word(SEND), "system register after clear");
      drain_stream();
      run_traffic(TRAFFIC_CYCLES, 1'b1, 4);
      drain_stream();
      read_frame_count("final frame count");
      read_check(`ACQ_REG_SYSTEM, status_word(IDLE), "final system register");

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: src.f
+incdir+logic
logic/acq_pkg.sv
logic/acq_sample_ram.sv
logic/acq_buffer_arbiter.sv
logic/acq_capture.sv
logic/acq_stream.sv
logic/acq_wb_regs.sv
logic/acq_top.sv
tb/acq_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = acq_tb
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
